// ==== source/lc3b_types.sv ====
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp; // n in bit 2, p in bit 0
	typedef logic [5:0] lc3b_offset6;
	typedef logic [8:0] lc3b_offset9;
	typedef logic [1:0] lc3b_sel;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	typedef struct packed {
		logic load_pc;
		logic load_ir;
		logic load_regfile;
		logic load_mar;
		logic load_mdr;
		logic load_cc;
		lc3b_sel pcmux_sel; // pc+2, branch target, alu, mdr
		logic storemux_sel; // sr1 or the dest field as register port a
		logic adj6mux_sel; // word scaled or byte offset
		logic destmux_sel; // dest field or r7
		lc3b_sel alumux_sel; // sr2, offset6, imm5, imm4
		lc3b_sel regfilemux_sel; // alu, mdr, pc, branch target
		lc3b_sel marmux_sel; // alu, pc, trap vector, mdr
		lc3b_sel mdrmux_sel; // alu, memory, byte store, byte load
		lc3b_aluop aluop;
	} lc3b_ctrl;

	typedef struct packed {
		lc3b_opcode opcode;
		logic branch_enable;
		logic immediate;
		logic jsr_trigger;
		logic a;
		logic d;
	} lc3b_status;

endpackage : lc3b_types

// ==== source/ir.sv ====
`timescale 1ns/1ps

module ir import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_word in,
	output lc3b_reg dest,
	output lc3b_reg src1,
	output lc3b_reg src2,
	output lc3b_offset6 offset6,
	output lc3b_offset9 offset9,
	output lc3b_word imm4,
	output lc3b_word imm5,
	output lc3b_word trapvect8,
	output lc3b_opcode opcode,
	output logic immediate,
	output logic jsr_trigger,
	output logic a,
	output logic d
);
	lc3b_word data;

	always_ff @(posedge clk)
	begin
		if (reset)
			data <= '0; // decodes as a branch that is never taken
		else if (load)
			data <= in;
	end

	assign opcode = lc3b_opcode'(data[15:12]);
	assign dest = data[11:9]; // also the nzp mask of BR
	assign src1 = data[8:6];
	assign src2 = data[2:0];
	assign offset6 = data[5:0];
	assign offset9 = data[8:0];
	assign imm4 = {12'h000, data[3:0]};
	assign imm5 = {{11{data[4]}}, data[4:0]};
	assign trapvect8 = {7'd0, data[7:0], 1'b0};
	assign immediate = data[5];
	assign jsr_trigger = data[11]; // set for JSR, clear for JSRR
	assign a = data[5]; // arithmetic right shift
	assign d = data[4]; // shift direction is right when set
endmodule : ir

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_word in,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	input lc3b_reg dest,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);
	lc3b_word data [8];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 8; i++)
				data[i] <= '0;
		end
		else if (load)
		begin
			data[dest] <= in;
		end
	end

	assign reg_a = data[src_a];
	assign reg_b = data[src_b];
endmodule : regfile

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import lc3b_types::*;
(
	input lc3b_aluop aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word f
);
	always_comb
	begin
		case (aluop)
			alu_add:
				f = a + b;
			alu_and:
				f = a & b;
			alu_not:
				f = ~a;
			alu_sll:
				f = a << b[3:0];
			alu_srl:
				f = a >> b[3:0];
			alu_sra:
				f = lc3b_word'($signed(a) >>> b[3:0]);
			default:
				f = a; // alu_pass and the unused code
		endcase
	end
endmodule : alu

// ==== source/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath import lc3b_types::*;
#(
	parameter lc3b_word reset_vector = 16'h0000
)
(
	input logic clk,
	input logic reset,
	input lc3b_ctrl ctrl,
	input lc3b_word mem_rdata,
	output lc3b_status status,
	output lc3b_word mem_address,
	output lc3b_word mem_wdata
);
	lc3b_word pc, mar, mdr;
	lc3b_nzp cc, gencc_out;
	lc3b_reg src1, src2, dest;
	lc3b_reg storemux_out, destmux_out;
	lc3b_offset6 offset6;
	lc3b_offset9 offset9;
	lc3b_word imm4, imm5, trapvect8;
	lc3b_word reg_a, reg_b, alu_out;
	lc3b_word pc_plus2, adj6_word, adj6_byte, adj6mux_out, adj9_out, br_add;
	lc3b_word pcmux_out, alumux_out, regfilemux_out, marmux_out, mdrmux_out;
	lc3b_word load_byte, store_byte;
	lc3b_opcode opcode;
	logic immediate, jsr_trigger, a, d;

	ir i_ir
	(
		.clk, .reset, .load(ctrl.load_ir), .in(mdr),
		.dest, .src1, .src2, .offset6, .offset9,
		.imm4, .imm5, .trapvect8,
		.opcode, .immediate, .jsr_trigger, .a, .d
	);

	regfile i_regfile
	(
		.clk, .reset, .load(ctrl.load_regfile), .in(regfilemux_out),
		.src_a(storemux_out), .src_b(src2), .dest(destmux_out),
		.reg_a, .reg_b
	);

	alu i_alu
	(
		.aluop(ctrl.aluop), .a(reg_a), .b(alumux_out), .f(alu_out)
	);

	assign pc_plus2 = pc + 16'd2;
	assign adj6_word = {{9{offset6[5]}}, offset6, 1'b0};
	assign adj6_byte = {{10{offset6[5]}}, offset6};
	assign adj9_out = {{6{offset9[8]}}, offset9, 1'b0};
	assign br_add = pc + adj9_out; // pc already points past the instruction

	assign storemux_out = ctrl.storemux_sel ? dest : src1;
	assign destmux_out = ctrl.destmux_sel ? 3'd7 : dest;
	assign adj6mux_out = ctrl.adj6mux_sel ? adj6_byte : adj6_word;

	// byte loads take the lane that MAR bit 0 points at
	assign load_byte = {8'h00, mar[0] ? mem_rdata[15:8] : mem_rdata[7:0]};
	assign store_byte = {alu_out[7:0], alu_out[7:0]};

	always_comb
	begin
		case (ctrl.pcmux_sel)
			2'd0: pcmux_out = pc_plus2;
			2'd1: pcmux_out = br_add;
			2'd2: pcmux_out = alu_out;
			default: pcmux_out = mdr;
		endcase
		case (ctrl.alumux_sel)
			2'd0: alumux_out = reg_b;
			2'd1: alumux_out = adj6mux_out;
			2'd2: alumux_out = imm5;
			default: alumux_out = imm4;
		endcase
		case (ctrl.regfilemux_sel)
			2'd0: regfilemux_out = alu_out;
			2'd1: regfilemux_out = mdr;
			2'd2: regfilemux_out = pc; // return address for JSR and JSRR
			default: regfilemux_out = br_add;
		endcase
		case (ctrl.marmux_sel)
			2'd0: marmux_out = alu_out;
			2'd1: marmux_out = pc;
			2'd2: marmux_out = trapvect8;
			default: marmux_out = mdr;
		endcase
		case (ctrl.mdrmux_sel)
			2'd0: mdrmux_out = alu_out;
			2'd1: mdrmux_out = mem_rdata;
			2'd2: mdrmux_out = store_byte;
			default: mdrmux_out = load_byte;
		endcase
	end

	assign gencc_out = regfilemux_out[15] ? 3'b100 :
		(regfilemux_out == 16'h0000) ? 3'b010 : 3'b001;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= reset_vector;
			cc <= 3'b010;
		end
		else
		begin
			if (ctrl.load_pc)
				pc <= pcmux_out;
			if (ctrl.load_cc)
				cc <= gencc_out;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.load_mar)
			mar <= marmux_out;
		if (ctrl.load_mdr)
			mdr <= mdrmux_out;
	end

	always_comb
	begin
		status.opcode = opcode;
		status.branch_enable = |(dest & cc); // dest holds the nzp mask
		status.immediate = immediate;
		status.jsr_trigger = jsr_trigger;
		status.a = a;
		status.d = d;
	end

	assign mem_address = mar;
	assign mem_wdata = mdr;
endmodule : cpu_datapath

// ==== source/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic mem_resp,
	input lc3b_status status,
	input logic mem_address_lsb,
	output lc3b_ctrl ctrl,
	output logic mem_read,
	output logic mem_write,
	output logic [1:0] mem_byte_enable
);
	typedef enum logic [4:0] {
		s_fetch1, s_fetch2, s_fetch3, s_decode,
		s_alu, s_shf, s_br, s_br_taken, s_jmp, s_jsr, s_lea,
		s_calc_addr, s_ldr, s_str, s_ldb, s_stb, s_ld_wb
	} state_e;

	state_e state, next_state;

	always_comb
	begin
		ctrl = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_byte_enable = 2'b11;
		case (state)
			s_fetch1:
			begin
				ctrl.marmux_sel = 2'd1;
				ctrl.load_mar = 1'b1;
			end
			s_fetch2, s_ldr, s_ldb:
			begin
				mem_read = 1'b1;
				ctrl.mdrmux_sel = (state == s_ldb) ? 2'd3 : 2'd1;
				ctrl.load_mdr = mem_resp;
			end
			s_fetch3:
			begin
				ctrl.load_ir = 1'b1;
				ctrl.load_pc = 1'b1;
			end
			s_decode:
			begin
				// store data is latched here so the address cycle has the ALU to itself
				ctrl.storemux_sel = 1'b1;
				ctrl.aluop = alu_pass;
				ctrl.mdrmux_sel = (status.opcode == op_stb) ? 2'd2 : 2'd0;
				ctrl.load_mdr = (status.opcode == op_str) || (status.opcode == op_stb);
			end
			s_alu:
			begin
				if (status.opcode == op_and)
					ctrl.aluop = alu_and;
				else if (status.opcode == op_not)
					ctrl.aluop = alu_not;
				ctrl.alumux_sel = status.immediate ? 2'd2 : 2'd0;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			s_shf:
			begin
				if (!status.d)
					ctrl.aluop = alu_sll;
				else
					ctrl.aluop = status.a ? alu_sra : alu_srl;
				ctrl.alumux_sel = 2'd3;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			s_br_taken:
			begin
				ctrl.pcmux_sel = 2'd1;
				ctrl.load_pc = 1'b1;
			end
			s_jmp, s_jsr:
			begin
				ctrl.aluop = alu_pass;
				ctrl.pcmux_sel = (state == s_jsr && status.jsr_trigger) ? 2'd1 : 2'd2;
				ctrl.load_pc = 1'b1;
				ctrl.destmux_sel = 1'b1; // r7 takes the return address on JSR
				ctrl.regfilemux_sel = 2'd2;
				ctrl.load_regfile = (state == s_jsr);
			end
			s_lea:
			begin
				ctrl.regfilemux_sel = 2'd3;
				ctrl.load_regfile = 1'b1;
			end
			s_calc_addr:
			begin
				ctrl.alumux_sel = 2'd1;
				ctrl.adj6mux_sel = (status.opcode == op_ldb) || (status.opcode == op_stb);
				ctrl.load_mar = 1'b1;
			end
			s_str, s_stb:
			begin
				mem_write = 1'b1;
				if (state == s_stb)
					mem_byte_enable = mem_address_lsb ? 2'b10 : 2'b01;
			end
			s_ld_wb:
			begin
				ctrl.regfilemux_sel = 2'd1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			default: ; // s_br is a not-taken branch and does nothing
		endcase
	end

	always_comb
	begin
		next_state = s_fetch1;
		case (state)
			s_fetch1: next_state = s_fetch2;
			s_fetch2: next_state = mem_resp ? s_fetch3 : s_fetch2;
			s_fetch3: next_state = s_decode;
			s_decode:
			begin
				case (status.opcode)
					op_add, op_and, op_not: next_state = s_alu;
					op_shf: next_state = s_shf;
					op_br: next_state = status.branch_enable ? s_br_taken : s_br;
					op_jmp: next_state = s_jmp;
					op_jsr: next_state = s_jsr;
					op_lea: next_state = s_lea;
					op_ldr, op_str, op_ldb, op_stb: next_state = s_calc_addr;
					default: next_state = s_fetch1; // trap and the opcodes left out act as no-ops
				endcase
			end
			s_calc_addr:
			begin
				case (status.opcode)
					op_ldr: next_state = s_ldr;
					op_ldb: next_state = s_ldb;
					op_str: next_state = s_str;
					default: next_state = s_stb;
				endcase
			end
			s_ldr, s_ldb: next_state = mem_resp ? s_ld_wb : state;
			s_str, s_stb: next_state = mem_resp ? s_fetch1 : state;
			default: next_state = s_fetch1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= s_fetch1;
		else
			state <= next_state;
	end
endmodule : cpu_control

// ==== source/cpu.sv ====
`timescale 1ns/1ps

module cpu import lc3b_types::*;
#(
	parameter lc3b_word reset_vector = 16'h0000
)
(
	input logic clk,
	input logic reset,
	input logic mem_resp,
	input lc3b_word mem_rdata,
	output logic mem_read,
	output logic mem_write,
	output logic [1:0] mem_byte_enable,
	output lc3b_word mem_address,
	output lc3b_word mem_wdata
);
	lc3b_ctrl ctrl;
	lc3b_status status;

	cpu_datapath #(.reset_vector(reset_vector)) i_datapath
	(
		.clk, .reset, .ctrl, .mem_rdata,
		.status, .mem_address, .mem_wdata
	);

	cpu_control i_control
	(
		.clk, .reset, .mem_resp, .status,
		.mem_address_lsb(mem_address[0]), // picks the byte lane for STB
		.ctrl, .mem_read, .mem_write, .mem_byte_enable
	);
endmodule : cpu

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import lc3b_types::*;
();
	localparam lc3b_word start_addr = 16'h0020;
	localparam lc3b_word data_base = start_addr + 16'h0100; // reached by LEA r6 with offset 127
	localparam int num_tests = 5;

	logic clk;
	logic reset;
	logic mem_resp;
	lc3b_word mem_rdata;
	logic mem_read;
	logic mem_write;
	logic [1:0] mem_byte_enable;
	lc3b_word mem_address;
	lc3b_word mem_wdata;

	logic [7:0] memory [65536];
	lc3b_word prog_addr;
	logic [1:0] last_write_be;
	lc3b_word last_write_addr;

	cpu #(.reset_vector(start_addr)) i_cpu
	(
		.clk, .reset, .mem_resp, .mem_rdata, .mem_read, .mem_write,
		.mem_byte_enable, .mem_address, .mem_wdata
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin : memory_model
		int latency;
		int wait_count;
		mem_resp = 1'b0;
		mem_rdata = '0;
		last_write_be = 2'b00;
		last_write_addr = '0;
		latency = 1;
		wait_count = 0;
		forever
		begin
			@(posedge clk);
			#1;
			if (mem_resp)
			begin
				mem_resp = 1'b0; // the access completed on this edge
			end
			else if (mem_read || mem_write)
			begin
				wait_count++;
				if (wait_count >= latency)
				begin
					if (mem_write)
					begin
						if (mem_byte_enable[0])
							memory[{mem_address[15:1], 1'b0}] = mem_wdata[7:0];
						if (mem_byte_enable[1])
							memory[{mem_address[15:1], 1'b1}] = mem_wdata[15:8];
						last_write_be = mem_byte_enable;
						last_write_addr = mem_address;
					end
					else
					begin
						mem_rdata = {memory[{mem_address[15:1], 1'b1}],
							memory[{mem_address[15:1], 1'b0}]};
					end
					mem_resp = 1'b1;
					wait_count = 0;
					latency = 1 + int'($urandom % 3);
				end
			end
			else
			begin
				wait_count = 0;
			end
		end
	end

	initial
	begin
		repeat (num_tests * 40 * 12) @(posedge clk);
		$display("the program did not halt within the cycle limit");
		$display("Something failed");
		$fatal(1);
	end

	function automatic lc3b_word three_field(lc3b_opcode op, lc3b_reg r1, lc3b_reg r2,
		logic [5:0] low);
		return {op, r1, r2, low};
	endfunction

	function automatic lc3b_word pc_relative(lc3b_opcode op, lc3b_reg r1, lc3b_offset9 off);
		return {op, r1, off};
	endfunction

	function automatic lc3b_word word_at(lc3b_word addr);
		return {memory[addr + 16'd1], memory[addr]};
	endfunction

	task automatic put_word(input lc3b_word addr, input lc3b_word w);
		memory[addr] = w[7:0];
		memory[addr + 16'd1] = w[15:8];
	endtask

	task automatic emit(input lc3b_word w);
		put_word(prog_addr, w);
		prog_addr = prog_addr + 16'd2;
	endtask

	task automatic halt;
		emit(pc_relative(op_br, 3'b111, 9'h1ff)); // branch back onto itself
	endtask

	task automatic start_program;
		for (int i = 0; i < 65536; i++)
			memory[i] = i[7:0] ^ i[15:8] ^ 8'h3c;
		prog_addr = start_addr;
		emit(pc_relative(op_lea, 3'd6, 9'd127));
	endtask

	task automatic check(input string name, input lc3b_word actual, input lc3b_word expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual,
				expected);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic run_program;
		lc3b_word last_fetch;
		logic fetched;
		logic prev_read;
		logic halted;
		last_fetch = '0;
		fetched = 1'b0;
		prev_read = 1'b0;
		halted = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		while (!halted)
		begin
			@(negedge clk);
			if (!fetched)
				check("mem_write", {15'd0, mem_write}, 16'h0000);
			if (mem_read && !prev_read)
			begin
				if (!fetched)
					check("mem_address", mem_address, start_addr); // first fetch from reset_vector
				else if (mem_address == last_fetch)
					halted = 1'b1; // the same address twice in a row is the halt loop
				last_fetch = mem_address;
				fetched = 1'b1;
			end
			prev_read = mem_read;
		end
		@(posedge clk);
		#1;
		reset = 1'b1;
	endtask

	task automatic arithmetic_test;
		lc3b_word a;
		lc3b_word b;
		a = lc3b_word'($urandom);
		b = lc3b_word'($urandom);
		start_program;
		put_word(data_base, a);
		put_word(data_base + 16'd2, b);
		emit(three_field(op_ldr, 3'd1, 3'd6, 6'd0));
		emit(three_field(op_ldr, 3'd2, 3'd6, 6'd1));
		emit(three_field(op_add, 3'd3, 3'd1, 6'd2));
		emit(three_field(op_add, 3'd4, 3'd1, 6'b111101)); // imm5 of -3
		emit(three_field(op_and, 3'd5, 3'd1, 6'd2));
		emit(three_field(op_str, 3'd3, 3'd6, 6'd2));
		emit(three_field(op_str, 3'd4, 3'd6, 6'd3));
		emit(three_field(op_str, 3'd5, 3'd6, 6'd4));
		emit(three_field(op_and, 3'd3, 3'd2, 6'b101101));
		emit(three_field(op_not, 3'd4, 3'd2, 6'b111111));
		emit(three_field(op_str, 3'd3, 3'd6, 6'd5));
		emit(three_field(op_str, 3'd4, 3'd6, 6'd6));
		halt;
		run_program;
		check("ADD register", word_at(data_base + 16'd4), a + b);
		check("ADD immediate", word_at(data_base + 16'd6), a + 16'hfffd);
		check("AND register", word_at(data_base + 16'd8), a & b);
		check("AND immediate", word_at(data_base + 16'd10), b & 16'h000d);
		check("NOT", word_at(data_base + 16'd12), ~b);
	endtask

	task automatic shift_test;
		lc3b_word v;
		v = lc3b_word'($urandom) | 16'h8000;
		start_program;
		put_word(data_base, v);
		emit(three_field(op_ldr, 3'd1, 3'd6, 6'd0));
		emit(three_field(op_shf, 3'd2, 3'd1, 6'b000011));
		emit(three_field(op_shf, 3'd3, 3'd1, 6'b010101));
		emit(three_field(op_shf, 3'd4, 3'd1, 6'b110101));
		emit(three_field(op_str, 3'd2, 3'd6, 6'd1));
		emit(three_field(op_str, 3'd3, 3'd6, 6'd2));
		emit(three_field(op_str, 3'd4, 3'd6, 6'd3));
		halt;
		run_program;
		check("SHF left", word_at(data_base + 16'd2), v << 3);
		check("SHF right logical", word_at(data_base + 16'd4), v >> 5);
		check("SHF right arithmetic", word_at(data_base + 16'd6), (v >> 5) | 16'hf800);
	endtask

	task automatic branch_test;
		string sign;
		logic taken;
		start_program;
		emit(three_field(op_add, 3'd5, 3'd0, 6'b101011)); // marker value 11
		for (int kind = 0; kind < 3; kind++)
		begin
			case (kind)
				0: emit(three_field(op_add, 3'd1, 3'd0, 6'b100001));
				1: emit(three_field(op_and, 3'd1, 3'd0, 6'b100000));
				default: emit(three_field(op_add, 3'd1, 3'd0, 6'b111111));
			endcase
			for (int mask = 0; mask < 8; mask++)
			begin
				put_word(data_base + lc3b_word'(16 * kind + 2 * mask), 16'h0000);
				emit(pc_relative(op_br, lc3b_reg'(mask), 9'd1));
				emit(pc_relative(op_br, 3'b111, 9'd1)); // not taken hops over the store
				emit(three_field(op_str, 3'd5, 3'd6, 6'(8 * kind + mask)));
			end
		end
		halt;
		run_program;
		for (int kind = 0; kind < 3; kind++)
		begin
			case (kind)
				0: sign = "positive";
				1: sign = "zero";
				default: sign = "negative";
			endcase
			for (int mask = 0; mask < 8; mask++)
			begin
				taken = mask[kind]; // p, z and n are mask bits 0, 1 and 2
				check($sformatf("BR marker after %s result mask %0d", sign, mask),
					word_at(data_base + lc3b_word'(16 * kind + 2 * mask)),
					taken ? 16'd11 : 16'd0);
			end
		end
	endtask

	task automatic jump_test;
		start_program;
		emit(pc_relative(op_jsr, 3'b100, 9'd8));
		emit(three_field(op_str, 3'd7, 3'd6, 6'd0));
		emit(pc_relative(op_lea, 3'd4, 9'd11));
		emit(three_field(op_jsr, 3'd0, 3'd4, 6'd0));
		emit(three_field(op_str, 3'd7, 3'd6, 6'd1));
		halt;
		prog_addr = start_addr + 16'd20;
		emit(three_field(op_add, 3'd1, 3'd0, 6'b101001));
		emit(three_field(op_str, 3'd1, 3'd6, 6'd2));
		emit(three_field(op_jmp, 3'd0, 3'd7, 6'd0));
		prog_addr = start_addr + 16'd30;
		emit(three_field(op_add, 3'd2, 3'd0, 6'b101100));
		emit(three_field(op_str, 3'd2, 3'd6, 6'd3));
		emit(three_field(op_jmp, 3'd0, 3'd7, 6'd0));
		run_program;
		check("R7 after JSR", word_at(data_base), start_addr + 16'd4);
		check("R7 after JSRR", word_at(data_base + 16'd2), start_addr + 16'd10);
		check("JSR marker", word_at(data_base + 16'd4), 16'd9);
		check("JSRR marker", word_at(data_base + 16'd6), 16'd12);
	endtask

	task automatic byte_test;
		lc3b_word w;
		w = lc3b_word'($urandom);
		start_program;
		put_word(data_base + 16'd16, w);
		memory[data_base + 16'd20] = 8'hc3;
		memory[data_base + 16'd21] = 8'h9e;
		memory[data_base + 16'd24] = 8'h5a;
		memory[data_base + 16'd25] = ~w[7:0];
		emit(pc_relative(op_lea, 3'd1, 9'd40));
		emit(three_field(op_str, 3'd1, 3'd6, 6'd0));
		emit(three_field(op_ldr, 3'd2, 3'd6, 6'd8));
		emit(three_field(op_str, 3'd2, 3'd6, 6'd1));
		emit(three_field(op_ldb, 3'd3, 3'd6, 6'd20));
		emit(three_field(op_str, 3'd3, 3'd6, 6'd2));
		emit(three_field(op_ldb, 3'd4, 3'd6, 6'd21));
		emit(three_field(op_str, 3'd4, 3'd6, 6'd3));
		emit(three_field(op_stb, 3'd2, 3'd6, 6'd25));
		halt;
		run_program;
		check("LEA", word_at(data_base), start_addr + 16'd84);
		check("LDR round trip", word_at(data_base + 16'd2), w);
		check("LDB even", word_at(data_base + 16'd4), 16'h00c3);
		check("LDB odd", word_at(data_base + 16'd6), 16'h009e);
		check("STB word", word_at(data_base + 16'd24), {w[7:0], 8'h5a});
		check("mem_byte_enable", {14'd0, last_write_be}, 16'h0002);
		check("STB address", last_write_addr, data_base + 16'd25);
	endtask

	initial
	begin
		void'($urandom(46));
		reset = 1'b1;
		arithmetic_test;
		shift_test;
		branch_test;
		jump_test;
		byte_test;
		$display("Everything OK");
		$finish;
	end
endmodule : cpu_tb

// ==== cpu.f ====
source/lc3b_types.sv
source/ir.sv
source/regfile.sv
source/alu.sv
source/cpu_datapath.sv
source/cpu_control.sv
source/cpu.sv
testbench/cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing
TOP = cpu_tb
FILELIST = cpu.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_TEXT = Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
